// File: sources.f
hdl/pad_pkg.sv
hdl/pad_cfg_port.sv
hdl/pad_mux_table.sv
hdl/pad_route.sv
hdl/pad_ctrl_top.sv
verification/pad_ctrl_checker.sv
verification/pad_ctrl_tb.sv

// File: verification/pad_ctrl_tb.sv
// Pad control testbench
// Applies a step table of config handshakes and source patterns to the DUT
`timescale 1ns/100ps

module pad_ctrl_tb;
  import pad_pkg::*;

  localparam int N_STEPS = 15;
  localparam int LIMIT   = N_STEPS * 10 + 50;

  logic                  io;
  logic                  reset_i;
  logic                  cfg_req_i;
  cfg_word_u             cfg_word_i;
  logic                  cfg_ack_o;
  src_bus_t              perio_i;
  src_bus_t              gpio_i;
  src_bus_t              fpgaio_i;
  logic [N_PADS-1:0]     pad_in_i;
  pad_bus_t              pad_o;
  logic [N_PADS-1:0]     perio_in_o;
  logic [N_PADS-1:0]     gpio_in_o;
  logic [N_PADS-1:0]     fpgaio_in_o;
  pad_cfg_t [N_PADS-1:0] pad_cfg_o;

  // Step kind 0 is a config word, 1 a source pattern
  logic              step_kind [N_STEPS];
  logic [11:0]       step_word [N_STEPS];
  logic [N_PADS-1:0] step_pin  [N_STEPS];
  integer            seed = 65;
  int                cycles = 0;

  pad_ctrl_top i_pad_ctrl_top (.*);

  pad_ctrl_checker i_chk (.*);

  function automatic logic [11:0] mux_word(input int pad, input pad_sel_t sel);
    return {1'b0, 4'(pad), sel, 5'b0};
  endfunction

  function automatic logic [11:0] cfg_word(input int pad, input pad_cfg_t cfg);
    return {1'b1, 4'(pad), cfg, 3'b0};
  endfunction

  initial begin
    io = 1'b0;
    forever #4 io = ~io;
  end

  always @(posedge io) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic send_cfg_word(input logic [11:0] w);
    @(posedge io);
    cfg_word_i <= w;
    cfg_req_i  <= 1'b1;
    do @(posedge io); while (!cfg_ack_o);
    cfg_req_i <= 1'b0;
    do @(posedge io); while (cfg_ack_o);
  endtask

  task automatic apply_sources(input logic [N_PADS-1:0] pin);
    @(posedge io);
    perio_i  <= {16'($random(seed)), 16'($random(seed))};
    gpio_i   <= {16'($random(seed)), 16'($random(seed))};
    fpgaio_i <= {16'($random(seed)), 16'($random(seed))};
    pad_in_i <= pin;
    repeat (5) @(posedge io);
  endtask

  initial begin
    step_kind = '{1, 0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 0, 1, 0, 1};
    step_pin  = '{default: '0};
    step_word = '{default: '0};
    step_word[1]  = mux_word(0, MUX_PERIO);
    step_word[2]  = mux_word(1, MUX_GPIO);
    step_word[3]  = mux_word(2, MUX_FPGAIO);
    step_word[4]  = mux_word(5, MUX_PERIO);
    step_word[5]  = cfg_word(0, 4'hA);
    step_word[6]  = cfg_word(15, 4'h5);
    step_pin[0]   = 16'h3c3c;
    step_pin[7]   = 16'hffff;
    step_pin[8]   = 16'h00a5;
    step_word[9]  = mux_word(0, MUX_GPIO);
    step_pin[10]  = 16'h5a5a;
    step_word[11] = mux_word(2, MUX_OFF);
    step_pin[12]  = 16'hc3c3;
    step_word[13] = cfg_word(1, 4'h3);
    step_pin[14]  = 16'h0f0f;

    reset_i    = 1'b1;
    cfg_req_i  = 1'b0;
    cfg_word_i = '0;
    perio_i    = '0;
    gpio_i     = '0;
    fpgaio_i   = '0;
    pad_in_i   = '0;
    repeat (5) @(posedge io);
    reset_i <= 1'b0;
    repeat (4) @(posedge io);

    for (int s = 0; s < N_STEPS; s++) begin
      if (step_kind[s] == 1'b0) begin
        send_cfg_word(step_word[s]);
      end else begin
        apply_sources(step_pin[s]);
      end
    end
    repeat (4) @(posedge io);

    $display("Errors: %0d", i_chk.err_count);
    if (i_chk.err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verification/pad_ctrl_checker.sv
// Pad control checker
// Rebuilds the pad table from accepted words and compares the DUT ports each cycle
`timescale 1ns/100ps

module pad_ctrl_checker (
  input logic                                    io,
  input logic                                    reset_i,
  input logic                                    cfg_req_i,
  input pad_pkg::cfg_word_u                      cfg_word_i,
  input logic                                    cfg_ack_o,
  input pad_pkg::src_bus_t                       perio_i,
  input pad_pkg::src_bus_t                       gpio_i,
  input pad_pkg::src_bus_t                       fpgaio_i,
  input logic [pad_pkg::N_PADS-1:0]              pad_in_i,
  input pad_pkg::pad_bus_t                       pad_o,
  input logic [pad_pkg::N_PADS-1:0]              perio_in_o,
  input logic [pad_pkg::N_PADS-1:0]              gpio_in_o,
  input logic [pad_pkg::N_PADS-1:0]              fpgaio_in_o,
  input pad_pkg::pad_cfg_t [pad_pkg::N_PADS-1:0] pad_cfg_o
);
  import pad_pkg::*;

  int                    err_count = 0;
  int                    n_seen = 0;
  // 0 idle, 1 word taken, 2 ack high, 3 ack held after req drop
  int                    hs_state;
  pad_sel_t [N_PADS-1:0] sel_m;
  pad_sel_t [N_PADS-1:0] sel_prev;
  pad_cfg_t [N_PADS-1:0] cfg_m;
  src_bus_t              perio_prev;
  src_bus_t              gpio_prev;
  src_bus_t              fpgaio_prev;
  pad_bus_t              exp_pad;
  logic [N_PADS-1:0]     in_h1;
  logic [N_PADS-1:0]     in_h2;
  logic [N_PADS-1:0]     in_h3;
  logic                  pend1_v;
  logic                  pend2_v;
  cfg_word_u             pend1_w;
  cfg_word_u             pend2_w;

  task automatic compare_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  function automatic logic [N_PADS-1:0] class_bits(input pad_sel_t [N_PADS-1:0] sel,
                                                    input pad_sel_t cls,
                                                    input logic [N_PADS-1:0] pin);
    logic [N_PADS-1:0] r;
    for (int p = 0; p < N_PADS; p++) begin
      r[p] = pin[p] & (sel[p] == cls);
    end
    return r;
  endfunction

  function automatic pad_bus_t drive_pads(input pad_sel_t [N_PADS-1:0] sel,
                                          input src_bus_t pe, input src_bus_t gp,
                                          input src_bus_t fp);
    pad_bus_t r;
    r = '0;
    for (int p = 0; p < N_PADS; p++) begin
      if (sel[p] == MUX_PERIO) begin
        r.out[p] = pe.out[p];
        r.oe[p]  = pe.oe[p];
      end else if (sel[p] == MUX_GPIO) begin
        r.out[p] = gp.out[p];
        r.oe[p]  = gp.oe[p];
      end else if (sel[p] == MUX_FPGAIO) begin
        r.out[p] = fp.out[p];
        r.oe[p]  = fp.oe[p];
      end
    end
    return r;
  endfunction

  // Sample between edges, where all DUT ports are settled
  always @(negedge io) begin
    if (reset_i !== 1'b0) begin
      sel_m       = {N_PADS{MUX_OFF}};
      sel_prev    = {N_PADS{MUX_OFF}};
      cfg_m       = '0;
      hs_state    = 0;
      pend1_v     = 1'b0;
      pend2_v     = 1'b0;
      perio_prev  = '0;
      gpio_prev   = '0;
      fpgaio_prev = '0;
    end else begin
      // Word accepted two samples ago is now in the table
      if (pend2_v) begin
        if (pend2_w.mux.kind == 1'b0) begin
          sel_m[pend2_w.mux.pad] = pend2_w.mux.sel;
        end else begin
          cfg_m[pend2_w.cfg.pad] = pend2_w.cfg.cfg;
        end
      end
      pend2_v = pend1_v;
      pend2_w = pend1_w;
      pend1_v = 1'b0;

      exp_pad = drive_pads(sel_prev, perio_prev, gpio_prev, fpgaio_prev);
      compare_val("cfg_ack_o", (hs_state == 2) || (hs_state == 3), cfg_ack_o);
      compare_val("pad_o.out", exp_pad.out, pad_o.out);
      compare_val("pad_o.oe", exp_pad.oe, pad_o.oe);
      compare_val("pad_cfg_o", cfg_m, pad_cfg_o);
      if (n_seen >= 3) begin
        compare_val("perio_in_o", class_bits(sel_prev, MUX_PERIO, in_h3), perio_in_o);
        compare_val("gpio_in_o", class_bits(sel_prev, MUX_GPIO, in_h3), gpio_in_o);
        compare_val("fpgaio_in_o", class_bits(sel_prev, MUX_FPGAIO, in_h3), fpgaio_in_o);
      end

      case (hs_state)
        0: if (cfg_req_i) begin
          pend1_v  = 1'b1;
          pend1_w  = cfg_word_i;
          hs_state = 1;
        end
        1: hs_state = 2;
        2: if (!cfg_req_i) hs_state = 3;
        default: hs_state = 0;
      endcase

      sel_prev    = sel_m;
      perio_prev  = perio_i;
      gpio_prev   = gpio_i;
      fpgaio_prev = fpgaio_i;
    end
    in_h3 = in_h2;
    in_h2 = in_h1;
    in_h1 = pad_in_i;
    n_seen++;
  end

endmodule

// File: hdl/pad_ctrl_top.sv
// Pad control top
// Config port, per-pad mux table and pad routing
`timescale 1ns/100ps

module pad_ctrl_top (
  input  logic                                    io,
  input  logic                                    reset_i,
  input  logic                                    cfg_req_i,
  input  pad_pkg::cfg_word_u                      cfg_word_i,
  output logic                                    cfg_ack_o,
  input  pad_pkg::src_bus_t                       perio_i,
  input  pad_pkg::src_bus_t                       gpio_i,
  input  pad_pkg::src_bus_t                       fpgaio_i,
  input  logic [pad_pkg::N_PADS-1:0]              pad_in_i,
  output pad_pkg::pad_bus_t                       pad_o,
  output logic [pad_pkg::N_PADS-1:0]              perio_in_o,
  output logic [pad_pkg::N_PADS-1:0]              gpio_in_o,
  output logic [pad_pkg::N_PADS-1:0]              fpgaio_in_o,
  output pad_pkg::pad_cfg_t [pad_pkg::N_PADS-1:0] pad_cfg_o
);
  import pad_pkg::*;

  pad_cmd_t              s_cmd;
  pad_sel_t [N_PADS-1:0] s_pad_sel;

  pad_cfg_port i_pad_cfg_port (
    .io         (io),
    .reset_i    (reset_i),
    .cfg_req_i  (cfg_req_i),
    .cfg_word_i (cfg_word_i),
    .cfg_ack_o  (cfg_ack_o),
    .cmd_o      (s_cmd)
  );

  pad_mux_table i_pad_mux_table (
    .io      (io),
    .reset_i (reset_i),
    .cmd_i   (s_cmd),
    .sel_o   (s_pad_sel),
    .cfg_o   (pad_cfg_o)
  );

  // Output register and input synchronizer
  pad_route i_pad_route (
    .io          (io),
    .reset_i     (reset_i),
    .sel_i       (s_pad_sel),
    .perio_i     (perio_i),
    .gpio_i      (gpio_i),
    .fpgaio_i    (fpgaio_i),
    .pad_in_i    (pad_in_i),
    .pad_o       (pad_o),
    .perio_in_o  (perio_in_o),
    .gpio_in_o   (gpio_in_o),
    .fpgaio_in_o (fpgaio_in_o)
  );

endmodule

// File: hdl/pad_route.sv
// Pad routing
// Drives pads from the selected source class and returns pad inputs to it
`timescale 1ns/100ps

module pad_route (
  input  logic                                    io,
  input  logic                                    reset_i,
  input  pad_pkg::pad_sel_t [pad_pkg::N_PADS-1:0] sel_i,
  input  pad_pkg::src_bus_t                       perio_i,
  input  pad_pkg::src_bus_t                       gpio_i,
  input  pad_pkg::src_bus_t                       fpgaio_i,
  input  logic [pad_pkg::N_PADS-1:0]              pad_in_i,
  output pad_pkg::pad_bus_t                       pad_o,
  output logic [pad_pkg::N_PADS-1:0]              perio_in_o,
  output logic [pad_pkg::N_PADS-1:0]              gpio_in_o,
  output logic [pad_pkg::N_PADS-1:0]              fpgaio_in_o
);
  import pad_pkg::*;

  pad_bus_t          pad_d;
  pad_bus_t          pad_q;
  logic [N_PADS-1:0] in_sync1_q;
  logic [N_PADS-1:0] in_sync2_q;
  logic [N_PADS-1:0] perio_in_q;
  logic [N_PADS-1:0] gpio_in_q;
  logic [N_PADS-1:0] fpgaio_in_q;

  // Per-pad out and oe from the selected class
  always_comb begin
    pad_d = '0;
    for (int p = 0; p < N_PADS; p++) begin
      case (sel_i[p])
        MUX_PERIO: begin
          pad_d.out[p] = perio_i.out[p];
          pad_d.oe[p]  = perio_i.oe[p];
        end
        MUX_GPIO: begin
          pad_d.out[p] = gpio_i.out[p];
          pad_d.oe[p]  = gpio_i.oe[p];
        end
        MUX_FPGAIO: begin
          pad_d.out[p] = fpgaio_i.out[p];
          pad_d.oe[p]  = fpgaio_i.oe[p];
        end
        MUX_OFF: begin
          pad_d.out[p] = 1'b0;
          pad_d.oe[p]  = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge io) begin
    if (reset_i) begin
      pad_q <= '0;
    end else begin
      pad_q <= pad_d;
    end
  end

  // Two-flop synchronizer on the pad inputs
  always_ff @(posedge io) begin
    in_sync1_q <= pad_in_i;
    in_sync2_q <= in_sync1_q;
  end

  // Each pad feeds only its selected class, the others read 0
  always_ff @(posedge io) begin
    if (reset_i) begin
      perio_in_q  <= '0;
      gpio_in_q   <= '0;
      fpgaio_in_q <= '0;
    end else begin
      for (int p = 0; p < N_PADS; p++) begin
        perio_in_q[p]  <= in_sync2_q[p] && (sel_i[p] == MUX_PERIO);
        gpio_in_q[p]   <= in_sync2_q[p] && (sel_i[p] == MUX_GPIO);
        fpgaio_in_q[p] <= in_sync2_q[p] && (sel_i[p] == MUX_FPGAIO);
      end
    end
  end

  assign pad_o       = pad_q;
  assign perio_in_o  = perio_in_q;
  assign gpio_in_o   = gpio_in_q;
  assign fpgaio_in_o = fpgaio_in_q;

  // A pad switched off in the table must not drive on the next cycle
  for (genvar p = 0; p < N_PADS; p++) begin : g_off_check
    a_off_no_oe: assert property (@(posedge io) disable iff (reset_i)
      (sel_i[p] == MUX_OFF) |=> !pad_o.oe[p]);
  end

endmodule

// File: hdl/pad_mux_table.sv
// Pad mux table
// Per-pad mux select and config registers, written by decoded commands
`timescale 1ns/100ps

module pad_mux_table (
  input  logic                                    io,
  input  logic                                    reset_i,
  input  pad_pkg::pad_cmd_t                       cmd_i,
  output pad_pkg::pad_sel_t [pad_pkg::N_PADS-1:0] sel_o,
  output pad_pkg::pad_cfg_t [pad_pkg::N_PADS-1:0] cfg_o
);
  import pad_pkg::*;

  pad_sel_t [N_PADS-1:0] sel_q;
  pad_cfg_t [N_PADS-1:0] cfg_q;
  logic     [N_PADS-1:0] sel_we;
  logic     [N_PADS-1:0] cfg_we;

  // One-hot enables from pad index and kind
  always_comb begin
    for (int p = 0; p < N_PADS; p++) begin
      sel_we[p] = cmd_i.valid
                  && (cmd_i.kind == KIND_MUX)
                  && (cmd_i.pad == PAD_IDX_W'(p));
      cfg_we[p] = cmd_i.valid
                  && (cmd_i.kind == KIND_CFG)
                  && (cmd_i.pad == PAD_IDX_W'(p));
    end
  end

  always_ff @(posedge io) begin
    if (reset_i) begin
      sel_q <= {N_PADS{MUX_OFF}};
      cfg_q <= '0;
    end else begin
      for (int p = 0; p < N_PADS; p++) begin
        if (sel_we[p]) begin
          sel_q[p] <= cmd_i.sel;
        end
        if (cfg_we[p]) begin
          cfg_q[p] <= cmd_i.cfg;
        end
      end
    end
  end

  assign sel_o = sel_q;
  assign cfg_o = cfg_q;

  // Unknown kind would corrupt the select or config of some pad
  a_kind_known: assert property (@(posedge io) disable iff (reset_i)
    cmd_i.valid |-> !$isunknown(cmd_i.kind));

endmodule

// File: hdl/pad_cfg_port.sv
// Pad configuration port
// Four-phase req/ack receiver, turns each accepted word into one write command
`timescale 1ns/100ps

module pad_cfg_port (
  input  logic               io,
  input  logic               reset_i,
  input  logic               cfg_req_i,
  input  pad_pkg::cfg_word_u cfg_word_i,
  output logic               cfg_ack_o,
  output pad_pkg::pad_cmd_t  cmd_o
);
  import pad_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_ACK,
    ST_DROP
  } state_e;

  state_e   state_q;
  state_e   state_d;
  logic     start;
  logic     valid_q;
  pad_cmd_t cmd_d;
  pad_cmd_t cmd_q;

  assign start = (state_q == ST_IDLE) && cfg_req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (cfg_req_i) state_d = ST_WRITE;
      ST_WRITE: state_d = ST_ACK;
      ST_ACK:   if (!cfg_req_i) state_d = ST_DROP;
      ST_DROP:  state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  // Read the word through the view named by its kind bit
  always_comb begin
    cmd_d      = '0;
    cmd_d.kind = cfg_word_i.mux.kind;
    if (cfg_word_i.mux.kind == KIND_CFG) begin
      cmd_d.pad = cfg_word_i.cfg.pad;
      cmd_d.cfg = cfg_word_i.cfg.cfg;
    end else begin
      cmd_d.pad = cfg_word_i.mux.pad;
      cmd_d.sel = cfg_word_i.mux.sel;
    end
  end

  always_ff @(posedge io) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= start;
    end
  end

  always_ff @(posedge io) begin
    if (start) begin
      cmd_q <= cmd_d;
    end
  end

  always_comb begin
    cmd_o       = cmd_q;
    cmd_o.valid = valid_q;
  end

  // Ack held through the drop cycle after req goes low
  assign cfg_ack_o = (state_q == ST_ACK) || (state_q == ST_DROP);

  // Master must still hold req in the cycle ack comes up
  a_ack_after_req: assert property (@(posedge io) disable iff (reset_i)
    $rose(cfg_ack_o) |-> $past(cfg_req_i));

  a_cmd_single: assert property (@(posedge io) disable iff (reset_i)
    cmd_o.valid |=> !cmd_o.valid);

endmodule

// File: hdl/pad_pkg.sv
// Pad control package
// Widths, mux codes, the configuration word union and pad bus types
package pad_pkg;

  localparam int N_PADS     = 16;
  localparam int PAD_IDX_W  = 4;
  localparam int MUX_W      = 2;
  localparam int PADCFG_W   = 4;
  localparam int CFG_WORD_W = 12;

  typedef logic [MUX_W-1:0]    pad_sel_t;
  typedef logic [PADCFG_W-1:0] pad_cfg_t;

  // Source class per pad
  localparam pad_sel_t MUX_PERIO  = 2'd0;
  localparam pad_sel_t MUX_GPIO   = 2'd1;
  localparam pad_sel_t MUX_FPGAIO = 2'd2;
  localparam pad_sel_t MUX_OFF    = 2'd3;

  // Top bit of the configuration word
  localparam logic KIND_MUX = 1'b0;
  localparam logic KIND_CFG = 1'b1;

  typedef struct packed {
    logic                                    kind;
    logic [PAD_IDX_W-1:0]                    pad;
    pad_sel_t                                sel;
    logic [CFG_WORD_W-PAD_IDX_W-MUX_W-2:0]   spare;
  } cfg_mux_view_t;

  typedef struct packed {
    logic                                    kind;
    logic [PAD_IDX_W-1:0]                    pad;
    pad_cfg_t                                cfg;
    logic [CFG_WORD_W-PAD_IDX_W-PADCFG_W-2:0] spare;
  } cfg_pad_view_t;

  // Same word, read as a mux write or a config write
  typedef union packed {
    cfg_mux_view_t mux;
    cfg_pad_view_t cfg;
  } cfg_word_u;

  typedef struct packed {
    logic                 valid;
    logic                 kind;
    logic [PAD_IDX_W-1:0] pad;
    pad_sel_t             sel;
    pad_cfg_t             cfg;
  } pad_cmd_t;

  typedef struct packed {
    logic [N_PADS-1:0] out;
    logic [N_PADS-1:0] oe;
  } src_bus_t;

  typedef struct packed {
    logic [N_PADS-1:0] out;
    logic [N_PADS-1:0] oe;
  } pad_bus_t;

endpackage
